// File: design/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

`default_nettype none

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// ADDI x0,x0,0
// Loaded into decode on a squash, and the source of every bubble
`define RV_NOP_INSN 32'h0000_0013

`default_nettype wire

`endif

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    opc_load   = 5'b00000,
    opc_op_imm = 5'b00100,
    opc_auipc  = 5'b00101,
    opc_store  = 5'b01000,
    opc_op     = 5'b01100,
    opc_lui    = 5'b01101,
    opc_branch = 5'b11000,
    opc_jalr   = 5'b11001,
    opc_jal    = 5'b11011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_load = 2'd1,
    wb_ret  = 2'd2
  } wb_sel_e;

  //////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////

  // Fetch to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] ret;
    logic [31:0] insn;
  } if_id_t;

  // Decode to execute
  typedef struct packed {
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] ret;
    alu_op_e     alu_op;
    logic [2:0]  funct3;
    opcode_e     opcode;
    // Operand A from pc, operand B from immediate
    logic        a_is_pc;
    logic        b_is_imm;
    logic        mem_rd;
    logic        mem_wr;
    wb_sel_e     wb_sel;
    logic [4:0]  rd;
    logic        wb_en;
  } id_ex_t;

  // Execute to memory access
  typedef struct packed {
    logic [31:0] result;
    logic [31:0] store_data;
    logic [31:0] ret;
    logic [2:0]  funct3;
    logic        mem_rd;
    logic        mem_wr;
    wb_sel_e     wb_sel;
    logic [4:0]  rd;
    logic        wb_en;
  } ex_ma_t;

  // Memory access to register file
  typedef struct packed {
    logic        wb_en;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic        i_clk,
  input  logic        i_rst,
  input  rv_pkg::wb_t i_wb,
  input  logic [4:0]  i_rs1,
  input  logic [4:0]  i_rs2,
  output logic [31:0] o_rs1_data,
  output logic [31:0] o_rs2_data
);

  // x1..x31, x0 has no storage
  logic [31:0] regs [1:31];

  // No writes while reset is applied
  always_ff @(posedge i_clk) begin
    if (!i_rst && i_wb.wb_en && (i_wb.rd != 5'd0)) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // Write-first, so write-back never needs an interlock
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return 32'd0;
    end
    if (i_wb.wb_en && (addr == i_wb.rd)) begin
      return i_wb.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule

`default_nettype wire

// File: design/rv_fetch.sv
`include "rv_core_config.svh"

`default_nettype none

module rv_fetch (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_ce,
  input  logic           i_stall,
  input  logic           i_redirect,
  input  logic [31:0]    i_target,
  input  logic [31:0]    i_insn,
  output logic [31:0]    o_pc,
  output rv_pkg::if_id_t o_if_id
);

  // Sequential next address, also the return address
  logic [31:0] pc_next;

  assign pc_next = o_pc + 32'd4;

  //////////////////////////////////////////////////
  // PC and fetch-to-decode register
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc         <= `RV_RESET_PC;
      o_if_id.insn <= `RV_NOP_INSN;
    end else if (i_ce) begin
      if (i_redirect) begin
        // Taken branch wins over a stall
        o_pc         <= i_target;
        // Fetched word is on the wrong path, squash it
        o_if_id.insn <= `RV_NOP_INSN;
      end else if (!i_stall) begin
        o_pc         <= pc_next;
        o_if_id.pc   <= o_pc;
        o_if_id.ret  <= pc_next;
        o_if_id.insn <= i_insn;
      end
      // Stalled: hold pc and refetch the same word
    end
  end

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`include "rv_core_config.svh"

`default_nettype none

module rv_decode (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_ce,
  input  logic           i_flush,
  input  rv_pkg::if_id_t i_if_id,
  input  rv_pkg::wb_t    i_wb,
  input  logic [4:0]     i_ma_rd,
  input  logic           i_ma_wb_en,
  output logic           o_stall,
  output rv_pkg::id_ex_t o_id_ex
);

  logic [4:0]     rs1;
  logic [4:0]     rs2;
  logic [31:0]    rs1_data;
  logic [31:0]    rs2_data;
  logic           use_rs1;
  logic           use_rs2;
  rv_pkg::id_ex_t dec;
  rv_pkg::id_ex_t bubble;
  rv_pkg::id_ex_t id_ex_next;

  assign rs1 = i_if_id.insn[19:15];
  assign rs2 = i_if_id.insn[24:20];

  // Register reads, write-back lands here too
  rv_regfile regfile_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wb       (i_wb),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////

  // funct3 to ALU op, alt picks sub or sra
  function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  // Control fields and immediate only, no operand data
  function automatic rv_pkg::id_ex_t decode_insn(input logic [31:0] insn);
    rv_pkg::id_ex_t d;
    logic [31:0]    imm_i;
    logic [31:0]    imm_s;
    logic [31:0]    imm_b;
    logic [31:0]    imm_u;
    logic [31:0]    imm_j;
    logic           writes;
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u = {insn[31:12], 12'd0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    d        = '0;
    d.opcode = rv_pkg::opcode_e'(insn[6:2]);
    d.funct3 = insn[14:12];
    d.rd     = insn[11:7];
    d.alu_op = rv_pkg::alu_add;
    d.wb_sel = rv_pkg::wb_alu;
    writes   = 1'b1;
    case (d.opcode)
      rv_pkg::opc_op: begin
        d.alu_op = alu_from_funct(d.funct3, insn[30]);
      end
      rv_pkg::opc_op_imm: begin
        // Only srai uses bit 30 among the immediates
        d.alu_op   = alu_from_funct(d.funct3, insn[30] && (d.funct3 == 3'b101));
        d.imm      = imm_i;
        d.b_is_imm = 1'b1;
      end
      rv_pkg::opc_load: begin
        d.imm      = imm_i;
        d.b_is_imm = 1'b1;
        d.mem_rd   = 1'b1;
        d.wb_sel   = rv_pkg::wb_load;
      end
      rv_pkg::opc_store: begin
        d.imm      = imm_s;
        d.b_is_imm = 1'b1;
        d.mem_wr   = 1'b1;
        writes     = 1'b0;
      end
      // ALU forms pc+imm as the target
      rv_pkg::opc_branch: begin
        d.imm      = imm_b;
        d.a_is_pc  = 1'b1;
        d.b_is_imm = 1'b1;
        writes     = 1'b0;
      end
      rv_pkg::opc_jal: begin
        d.imm      = imm_j;
        d.a_is_pc  = 1'b1;
        d.b_is_imm = 1'b1;
        d.wb_sel   = rv_pkg::wb_ret;
      end
      // rs1+imm, bit 0 cleared in execute
      rv_pkg::opc_jalr: begin
        d.imm      = imm_i;
        d.b_is_imm = 1'b1;
        d.wb_sel   = rv_pkg::wb_ret;
      end
      rv_pkg::opc_lui: begin
        d.alu_op   = rv_pkg::alu_pass_b;
        d.imm      = imm_u;
        d.b_is_imm = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        d.imm      = imm_u;
        d.a_is_pc  = 1'b1;
        d.b_is_imm = 1'b1;
      end
      default: begin
        // Unsupported, treated as a no-op
        d.opcode = rv_pkg::opc_op_imm;
        writes   = 1'b0;
      end
    endcase
    // No write for x0, so the no-op decodes with wb_en low
    d.wb_en = writes && (d.rd != 5'd0);
    return d;
  endfunction

  assign dec    = decode_insn(i_if_id.insn);
  assign bubble = decode_insn(`RV_NOP_INSN);

  //////////////////////////////////////////////////
  // Interlock
  //////////////////////////////////////////////////

  // Sources really read, so LUI, AUIPC and JAL never stall
  always_comb begin
    use_rs1 = !((dec.opcode == rv_pkg::opc_lui) || (dec.opcode == rv_pkg::opc_auipc) ||
                (dec.opcode == rv_pkg::opc_jal));
    use_rs2 = (dec.opcode == rv_pkg::opc_op) || (dec.opcode == rv_pkg::opc_store) ||
              (dec.opcode == rv_pkg::opc_branch);
  end

  // Pending in execute or memory access, write-back is bypassed
  function automatic logic src_pending(input logic [4:0] rs);
    return (rs != 5'd0) &&
           ((o_id_ex.wb_en && (rs == o_id_ex.rd)) || (i_ma_wb_en && (rs == i_ma_rd)));
  endfunction

  always_comb begin
    o_stall = (use_rs1 && src_pending(rs1)) || (use_rs2 && src_pending(rs2));
  end

  //////////////////////////////////////////////////
  // Decode-to-execute register
  //////////////////////////////////////////////////
  always_comb begin
    id_ex_next          = dec;
    id_ex_next.rs1_data = rs1_data;
    id_ex_next.rs2_data = rs2_data;
    id_ex_next.pc       = i_if_id.pc;
    id_ex_next.ret      = i_if_id.ret;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_id_ex <= bubble;
    end else if (i_ce) begin
      // Bubble on interlock or squash
      if (o_stall || i_flush) begin
        o_id_ex <= bubble;
      end else begin
        o_id_ex <= id_ex_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none

module rv_execute (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_ce,
  input  rv_pkg::id_ex_t i_id_ex,
  output logic           o_redirect,
  output logic [31:0]    o_target,
  output rv_pkg::ex_ma_t o_ex_ma
);

  logic [31:0]    op_a;
  logic [31:0]    op_b;
  logic [31:0]    result;
  logic           taken;
  logic           is_jalr;
  rv_pkg::ex_ma_t ex_ma_next;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  assign op_a = i_id_ex.a_is_pc  ? i_id_ex.pc  : i_id_ex.rs1_data;
  assign op_b = i_id_ex.b_is_imm ? i_id_ex.imm : i_id_ex.rs2_data;

  always_comb begin
    case (i_id_ex.alu_op)
      rv_pkg::alu_add:  result = op_a + op_b;
      rv_pkg::alu_sub:  result = op_a - op_b;
      rv_pkg::alu_sll:  result = op_a << op_b[4:0];
      rv_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: result = {31'd0, op_a < op_b};
      rv_pkg::alu_xor:  result = op_a ^ op_b;
      rv_pkg::alu_srl:  result = op_a >> op_b[4:0];
      rv_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> op_b[4:0]);
      rv_pkg::alu_or:   result = op_a | op_b;
      rv_pkg::alu_and:  result = op_a & op_b;
      default:          result = op_b;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch condition and target
  //////////////////////////////////////////////////

  // Compared on the register operands, ALU busy with pc+imm
  always_comb begin
    case (i_id_ex.funct3)
      3'b000:  taken = i_id_ex.rs1_data == i_id_ex.rs2_data;
      3'b001:  taken = i_id_ex.rs1_data != i_id_ex.rs2_data;
      3'b100:  taken = $signed(i_id_ex.rs1_data) <  $signed(i_id_ex.rs2_data);
      3'b101:  taken = $signed(i_id_ex.rs1_data) >= $signed(i_id_ex.rs2_data);
      3'b110:  taken = i_id_ex.rs1_data <  i_id_ex.rs2_data;
      3'b111:  taken = i_id_ex.rs1_data >= i_id_ex.rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign is_jalr    = i_id_ex.opcode == rv_pkg::opc_jalr;
  assign o_target   = {result[31:1], result[0] & !is_jalr};
  // Jumps always redirect
  assign o_redirect = ((i_id_ex.opcode == rv_pkg::opc_branch) && taken) ||
                      (i_id_ex.opcode == rv_pkg::opc_jal) || is_jalr;

  //////////////////////////////////////////////////
  // Execute-to-memory register
  //////////////////////////////////////////////////
  always_comb begin
    ex_ma_next.result     = result;
    ex_ma_next.store_data = i_id_ex.rs2_data;
    ex_ma_next.ret        = i_id_ex.ret;
    ex_ma_next.funct3     = i_id_ex.funct3;
    ex_ma_next.mem_rd     = i_id_ex.mem_rd;
    ex_ma_next.mem_wr     = i_id_ex.mem_wr;
    ex_ma_next.wb_sel     = i_id_ex.wb_sel;
    ex_ma_next.rd         = i_id_ex.rd;
    ex_ma_next.wb_en      = i_id_ex.wb_en;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ex_ma.mem_rd <= 1'b0;
      o_ex_ma.mem_wr <= 1'b0;
      o_ex_ma.wb_en  <= 1'b0;
    end else if (i_ce) begin
      o_ex_ma <= ex_ma_next;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_mem_access.sv
`default_nettype none

module rv_mem_access (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_ce,
  input  rv_pkg::ex_ma_t i_ex_ma,
  input  logic [31:0]    i_data_rd,
  output logic [31:0]    o_addr_d,
  output logic [3:0]     o_we_d,
  output logic           o_rd_d,
  output logic [31:0]    o_data_out_d,
  output rv_pkg::wb_t    o_wb
);

  logic [1:0]  lane;
  logic [3:0]  byte_en;
  logic [31:0] load_shifted;
  logic [31:0] load_data;
  logic [31:0] wb_data;

  // Byte offset within the word
  assign lane     = i_ex_ma.result[1:0];
  assign o_addr_d = i_ex_ma.result;
  assign o_rd_d   = i_ex_ma.mem_rd;
  assign o_we_d   = byte_en & {4{i_ex_ma.mem_wr}};

  //////////////////////////////////////////////////
  // Store lanes
  //////////////////////////////////////////////////

  // Replicate so every lane carries the value
  always_comb begin
    case (i_ex_ma.funct3[1:0])
      2'b00: begin
        byte_en      = 4'b0001 << lane;
        o_data_out_d = {4{i_ex_ma.store_data[7:0]}};
      end
      2'b01: begin
        byte_en      = lane[1] ? 4'b1100 : 4'b0011;
        o_data_out_d = {2{i_ex_ma.store_data[15:0]}};
      end
      default: begin
        byte_en      = 4'b1111;
        o_data_out_d = i_ex_ma.store_data;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Load extension and write-back select
  //////////////////////////////////////////////////
  assign load_shifted = i_data_rd >> {lane, 3'b000};

  // Bit 2 of funct3 selects zero extension
  always_comb begin
    case (i_ex_ma.funct3)
      3'b000:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
      3'b001:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
      3'b100:  load_data = {24'd0, load_shifted[7:0]};
      3'b101:  load_data = {16'd0, load_shifted[15:0]};
      default: load_data = load_shifted;
    endcase
  end

  always_comb begin
    case (i_ex_ma.wb_sel)
      rv_pkg::wb_load: wb_data = load_data;
      rv_pkg::wb_ret:  wb_data = i_ex_ma.ret;
      default:         wb_data = i_ex_ma.result;
    endcase
  end

  // Write-back register, read by the register file
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb.wb_en <= 1'b0;
    end else if (i_ce) begin
      o_wb.wb_en <= i_ex_ma.wb_en;
      o_wb.rd    <= i_ex_ma.rd;
      o_wb.data  <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core.sv
`default_nettype none

module rv_core (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_valid_i,
  input  logic        i_valid_d,
  input  logic [31:0] i_data_in_i,
  input  logic [31:0] i_data_in_d,
  output logic [31:0] o_addr_i,
  output logic [31:0] o_addr_d,
  output logic [3:0]  o_we_d,
  output logic        o_rd_d,
  output logic [31:0] o_data_out_d
);

  logic           ce;
  logic           stall;
  logic           redirect;
  logic [31:0]    target;
  rv_pkg::if_id_t if_id;
  rv_pkg::id_ex_t id_ex;
  rv_pkg::ex_ma_t ex_ma;
  rv_pkg::wb_t    wb;

  //////////////////////////////////////////////////
  // Clock enable
  //////////////////////////////////////////////////

  // Either port not ready freezes every stage
  assign ce = i_valid_i && i_valid_d;

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////
  rv_fetch fetch_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ce       (ce),
    .i_stall    (stall),
    .i_redirect (redirect),
    .i_target   (target),
    .i_insn     (i_data_in_i),
    .o_pc       (o_addr_i),
    .o_if_id    (if_id)
  );

  // Interlock checks the memory-access rd here
  rv_decode decode_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ce       (ce),
    .i_flush    (redirect),
    .i_if_id    (if_id),
    .i_wb       (wb),
    .i_ma_rd    (ex_ma.rd),
    .i_ma_wb_en (ex_ma.wb_en),
    .o_stall    (stall),
    .o_id_ex    (id_ex)
  );

  rv_execute execute_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ce       (ce),
    .i_id_ex    (id_ex),
    .o_redirect (redirect),
    .o_target   (target),
    .o_ex_ma    (ex_ma)
  );

  rv_mem_access mem_access_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ce         (ce),
    .i_ex_ma      (ex_ma),
    .i_data_rd    (i_data_in_d),
    .o_addr_d     (o_addr_d),
    .o_we_d       (o_we_d),
    .o_rd_d       (o_rd_d),
    .o_data_out_d (o_data_out_d),
    .o_wb         (wb)
  );

endmodule

`default_nettype wire

// File: dv/rv_clk_gen.sv
`default_nettype none

module rv_clk_gen (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // Held over 5 rising edges, released on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (5) @(posedge o_clk);
    @(negedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
`include "rv_core_config.svh"

`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BODY_LEN = 90;
  localparam int RST_CYCLES = 5;

  logic        clk;
  logic        rst;
  logic        valid_i;
  logic        valid_d;
  logic [31:0] data_in_i;
  logic [31:0] data_in_d;
  logic [31:0] addr_i;
  logic [31:0] addr_d;
  logic [3:0]  we_d;
  logic        rd_d;
  logic [31:0] data_out_d;

  // Program memory and the data window at 0x100..0x1ff
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:63];
  // Expected stores in program order
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_we [$];
  logic [31:0] exp_data [$];
  int          prog_len;
  int          store_cnt;
  int          cycles;
  int          limit;

  rv_clk_gen clk_gen_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_core dut_i (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_valid_i    (valid_i),
    .i_valid_d    (valid_d),
    .i_data_in_i  (data_in_i),
    .i_data_in_d  (data_in_d),
    .o_addr_i     (addr_i),
    .o_addr_d     (addr_d),
    .o_we_d       (we_d),
    .o_rd_d       (rd_d),
    .o_data_out_d (data_out_d)
  );

  // Same-cycle memory answers with read data gated by the strobe
  assign data_in_i = imem[addr_i[9:2]];
  assign data_in_d = (rd_d && (addr_d[31:8] == 24'd1)) ? dmem[addr_d[7:2]] : 32'd0;

  //////////////////////////////////////////////////
  // Encoders
  //////////////////////////////////////////////////
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Depends on every address bit
  function automatic logic [31:0] fill_word(int i);
    logic [31:0] a;
    a = 32'h100 + 32'(i) * 4;
    return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  //////////////////////////////////////////////////
  // Program generator
  //////////////////////////////////////////////////
  task automatic build_program();
    int          idx;
    int          kind;
    int          skip;
    logic [2:0]  f3;
    logic [11:0] off;
    logic [2:0]  load_f3 [5];
    logic [2:0]  br_f3 [6];
    load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 256; i++) imem[i] = `RV_NOP_INSN;
    for (int i = 0; i < 64; i++) dmem[i] = fill_word(i);
    idx = 0;
    // x16 holds the data base and is never written again
    imem[idx] = enc_i(12'h100, 5'd0, 3'd0, 5'd16, 7'b0010011);
    idx++;
    for (int r = 1; r < 16; r++) begin
      imem[idx] = {20'($urandom), 5'(r), 7'b0110111};
      idx++;
      imem[idx] = enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), 7'b0010011);
      idx++;
    end
    for (int i = 0; i < BODY_LEN; i++) begin
      kind = $urandom % 8;
      // Forward control flow stays inside the body
      if ((kind == 5 || kind == 6) && (i > BODY_LEN - 5)) kind = 0;
      skip = 1 + $urandom % 3;
      f3 = 3'($urandom);
      case (kind)
        0, 1: imem[idx] = enc_r({1'b0, (f3 == 0 || f3 == 5) && $urandom % 2, 5'd0},
                                5'($urandom % 16), 5'($urandom % 16), f3, 5'($urandom % 16));
        2: begin
          off = 12'($urandom);
          // Shift amounts with legal upper bits
          if (f3 == 1) off = {7'd0, off[4:0]};
          if (f3 == 5) off = {1'b0, off[10], 5'd0, off[4:0]};
          imem[idx] = enc_i(off, 5'($urandom % 16), f3, 5'($urandom % 16), 7'b0010011);
        end
        3: begin
          f3 = load_f3[$urandom % 5];
          off = 12'($urandom % 256) & ~((12'd1 << f3[1:0]) - 12'd1);
          imem[idx] = enc_i(off, 5'd16, f3, 5'($urandom % 16), 7'b0000011);
        end
        4: begin
          f3 = 3'($urandom % 3);
          off = 12'($urandom % 256) & ~((12'd1 << f3[1:0]) - 12'd1);
          imem[idx] = enc_s(off, 5'($urandom % 16), 5'd16, f3);
        end
        5: imem[idx] = enc_b(13'((skip + 1) * 4), 5'($urandom % 16), 5'($urandom % 16),
                             br_f3[$urandom % 6]);
        6: imem[idx] = enc_j(21'((skip + 1) * 4), 5'($urandom % 16));
        default: begin
          // JALR over one word with the target relative to x16
          if ($urandom % 2) begin
            imem[idx] = enc_i(12'((idx + 2) * 4 - 256), 5'd16, 3'd0, 5'($urandom % 16),
                              7'b1100111);
          end else begin
            imem[idx] = {20'($urandom), 5'($urandom % 16), 7'b0010111};
          end
        end
      endcase
      idx++;
    end
    // Dump every register and then spin
    for (int r = 1; r < 17; r++) begin
      imem[idx] = enc_s(12'((r - 1) * 4), 5'(r), 5'd16, 3'd2);
      idx++;
    end
    imem[idx] = enc_j(21'd0, 5'd0);
    idx++;
    prog_len = idx;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Architectural run that returns the number of stores
  function automatic int run_reference();
    logic [31:0] x [0:31];
    logic [31:0] mem [0:63];
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] nxt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] mask;
    logic [3:0]  we;
    logic [2:0]  f3;
    logic        wr;
    logic        cond;
    for (int i = 0; i < 32; i++) x[i] = 32'd0;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    pc = `RV_RESET_PC;
    for (int step = 0; step < 4096; step++) begin
      insn = imem[pc[9:2]];
      if (insn == 32'h0000_006F) break;
      a = x[insn[19:15]];
      b = x[insn[24:20]];
      f3 = insn[14:12];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      nxt = pc + 4;
      wr = 1'b1;
      res = 32'd0;
      case (insn[6:0])
        7'b0110111: res = {insn[31:12], 12'd0};
        7'b0010111: res = pc + {insn[31:12], 12'd0};
        7'b1101111: begin
          res = pc + 4;
          nxt = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'b1100111: begin
          res = pc + 4;
          nxt = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          wr = 1'b0;
          case (f3)
            3'd0:    cond = a == b;
            3'd1:    cond = a != b;
            3'd4:    cond = $signed(a) < $signed(b);
            3'd5:    cond = $signed(a) >= $signed(b);
            3'd6:    cond = a < b;
            default: cond = a >= b;
          endcase
          if (cond) nxt = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
        7'b0000011: begin
          v = a + imm_i;
          res = mem[v[7:2]] >> (8 * v[1:0]);
          if (f3 == 3'd0) res = {{24{res[7]}}, res[7:0]};
          if (f3 == 3'd1) res = {{16{res[15]}}, res[15:0]};
          if (f3 == 3'd4) res = {24'd0, res[7:0]};
          if (f3 == 3'd5) res = {16'd0, res[15:0]};
        end
        7'b0100011: begin
          wr = 1'b0;
          v = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
          // Lane enables and replicated data by size
          if (f3 == 3'd0) begin
            we = 4'b0001 << v[1:0];
            res = {4{b[7:0]}};
          end else if (f3 == 3'd1) begin
            we = 4'b0011 << v[1:0];
            res = {2{b[15:0]}};
          end else begin
            we = 4'b1111;
            res = b;
          end
          mask = {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
          mem[v[7:2]] = (mem[v[7:2]] & ~mask) | (res & mask);
          exp_addr.push_back(v);
          exp_we.push_back(we);
          exp_data.push_back(res & mask);
        end
        7'b0010011: res = alu_ref(f3, insn[30] && (f3 == 3'd5), a, imm_i);
        default:    res = alu_ref(f3, insn[30], a, b);
      endcase
      if (wr && insn[11:7] != 5'd0) x[insn[11:7]] = res;
      pc = nxt;
    end
    return exp_addr.size();
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic check_val(string name, logic [31:0] got, logic [31:0] expd);
    if (got !== expd) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, expd);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  // Valid levels drop on falling edges
  always @(negedge clk) begin
    if (rst) begin
      valid_i <= 1'b1;
      valid_d <= 1'b1;
    end else begin
      valid_i <= ($urandom % 8) != 0;
      valid_d <= ($urandom % 8) != 0;
    end
  end

  // Store compare on enabled cycles only
  always @(posedge clk) begin
    if (!rst && valid_i && valid_d && we_d != 4'd0) begin
      if (store_cnt >= exp_addr.size()) begin
        $display("Unexpected store at time %0t to address %h", $time, addr_d);
        $display(">>> FAIL");
        $fatal(1);
      end
      check_val("o_addr_d", addr_d, exp_addr[store_cnt]);
      check_val("o_we_d", {28'd0, we_d}, {28'd0, exp_we[store_cnt]});
      check_val("o_data_out_d", data_out_d & {{8{we_d[3]}}, {8{we_d[2]}}, {8{we_d[1]}},
                {8{we_d[0]}}}, exp_data[store_cnt]);
      for (int b = 0; b < 4; b++) begin
        if (we_d[b]) dmem[addr_d[7:2]][8*b +: 8] <= data_out_d[8*b +: 8];
      end
      store_cnt <= store_cnt + 1;
    end
  end

  // Timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles with %0d stores seen", cycles, store_cnt);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  initial begin
    int n_exp;
    int drained;
    valid_i = 1'b1;
    valid_d = 1'b1;
    store_cnt = 0;
    cycles = 0;
    limit = 100000;
    void'($urandom(12669));
    build_program();
    n_exp = run_reference();
    limit = 8 * prog_len + RST_CYCLES + 32;
    // Outputs while reset is held
    repeat (3) @(negedge clk);
    check_val("o_we_d", {28'd0, we_d}, 32'd0);
    check_val("o_rd_d", {31'd0, rd_d}, 32'd0);
    check_val("o_addr_i", addr_i, `RV_RESET_PC);
    wait (!rst);
    // Fetch reaching the final self-loop marks the end of the program
    while (addr_i != `RV_RESET_PC + 32'((prog_len - 1) * 4)) @(posedge clk);
    // Enabled cycles for the last stores to leave the pipeline
    drained = 0;
    while (drained < 8) begin
      @(posedge clk);
      if (valid_i && valid_d) drained++;
    end
    if (store_cnt == n_exp) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("Store count %0d differs from expected %0d", store_cnt, n_exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_access.sv
design/rv_core.sv
dv/rv_clk_gen.sv
dv/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
